// ==== src/flit_buffer_settings.svh ====
`ifndef FLIT_BUFFER_SETTINGS_SVH
`define FLIT_BUFFER_SETTINGS_SVH

// sizing of the vc input buffer

// virtual channels sharing the flit ram
`define FB_NUM_VC 2

// flit slots owned by each channel
// must stay a power of two so the
// per-channel pointers wrap on their own
`define FB_SLOTS_PER_VC 4

// payload bits carried by one flit
`define FB_PAYLOAD_W 32

// total ram depth is FB_NUM_VC * FB_SLOTS_PER_VC words

`endif

// ==== src/flit_buffer_pkg.sv ====
`default_nettype none

`include "flit_buffer_settings.svh"

package flit_buffer_pkg;

    // field widths derived from the sizing macros
    localparam int PTR_W    = (`FB_SLOTS_PER_VC > 1) ? $clog2(`FB_SLOTS_PER_VC) : 1;
    localparam int VC_IDX_W = (`FB_NUM_VC > 1) ? $clog2(`FB_NUM_VC) : 1;

    // one-hot channel vector
    typedef logic [`FB_NUM_VC-1:0] vc_mask_t;

    // binary channel number
    typedef logic [VC_IDX_W-1:0] vc_idx_t;

    // slot inside one channel, and its occupancy (one bit wider for full)
    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   depth_t;

    // incoming flit, vc field rides along but is not stored
    typedef struct packed {
        logic                     hdr_flag;
        logic                     tail_flag;
        vc_mask_t                 vc;
        logic [`FB_PAYLOAD_W-1:0] payload;
    } flit_t;

    // word held in the ram and driven on dout
    typedef struct packed {
        logic                     hdr_flag;
        logic                     tail_flag;
        logic [`FB_PAYLOAD_W-1:0] payload;
    } ram_word_t;

    // channel in the upper bits, slot in the lower bits
    typedef struct packed {
        vc_idx_t vc;
        ptr_t    slot;
    } ram_addr_t;

endpackage

`default_nettype wire

// ==== src/vc_depth_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_settings.svh"

// bookkeeping for one virtual channel queue
module vc_depth_counter
    import flit_buffer_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  logic pop,
    output ptr_t wr_ptr,
    output ptr_t rd_ptr,
    output logic push_ok,
    output logic pop_ok,
    output logic not_empty
);

    // occupancy value meaning all slots used
    localparam depth_t FULL_DEPTH = depth_t'(`FB_SLOTS_PER_VC);

    depth_t depth;
    logic   is_full;
    logic   is_empty;

    // status from the depth before the edge
    assign is_full  = (depth == FULL_DEPTH);
    assign is_empty = (depth == '0);

    // push dropped when full, pop ignored when empty
    // both judged on the old depth, so push+pop on a full channel
    // only pops, and push+pop on an empty one only pushes
    assign push_ok   = push & ~is_full;
    assign pop_ok    = pop & ~is_empty;
    assign not_empty = ~is_empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            depth  <= '0;
        end else begin
            // power of two slots, so plain increment wraps
            if (push_ok) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            // depth moves only when exactly one side is accepted
            case ({push_ok, pop_ok})
                2'b10: depth <= depth + depth_t'(1);
                2'b01: depth <= depth - depth_t'(1);
                default: depth <= depth;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/vc_addr_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_settings.svh"

// one-hot channel plus that channel's pointer -> ram address
module vc_addr_select
    import flit_buffer_pkg::*;
(
    input  vc_mask_t  vc_sel,
    input  ptr_t      ptrs [`FB_NUM_VC],
    output ram_addr_t addr
);

    vc_idx_t vc_bin;
    ptr_t    slot_sel;

    // one-hot to binary
    // or together the index of every set bit
    always_comb begin
        vc_bin = '0;
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            vc_bin = vc_bin | (vc_idx_t'(i) & {VC_IDX_W{vc_sel[i]}});
        end
    end

    // and-or mux over the per-channel pointers
    // each pointer masked by its select bit
    always_comb begin
        slot_sel = '0;
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            slot_sel = slot_sel | (ptrs[i] & {PTR_W{vc_sel[i]}});
        end
    end

    // no select bit set gives address zero
    // harmless, the matching ram enable is low then
    assign addr.vc   = vc_bin;
    assign addr.slot = slot_sel;

endmodule

`default_nettype wire

// ==== src/flit_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_settings.svh"

// shared flit storage, one region of slots per channel
module flit_ram
    import flit_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  logic      rd_en,
    input  ram_addr_t wr_addr,
    input  ram_addr_t rd_addr,
    input  ram_word_t wr_data,
    output ram_word_t rd_data
);

    localparam int DEPTH = `FB_NUM_VC * `FB_SLOTS_PER_VC;

    ram_word_t mem [DEPTH];

    // write lands at the edge
    // registered read, output holds while rd_en is low
    // a pop never targets the slot being pushed in the same cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/flit_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_settings.svh"

// noc router input buffer, virtual channels over one flit ram
module flit_buffer
    import flit_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  flit_t     din,
    input  vc_mask_t  vc_num_wr,
    input  vc_mask_t  vc_num_rd,
    input  logic      wr_en,
    input  logic      rd_en,
    output ram_word_t dout,
    output vc_mask_t  vc_not_empty
);

    // per-channel strobes and accept pulses
    vc_mask_t  push;
    vc_mask_t  pop;
    vc_mask_t  push_ok;
    vc_mask_t  pop_ok;

    // pointers gathered per channel for the address selects
    ptr_t      wr_ptrs [`FB_NUM_VC];
    ptr_t      rd_ptrs [`FB_NUM_VC];

    ram_addr_t wr_addr;
    ram_addr_t rd_addr;
    ram_word_t ram_din;
    logic      ram_wr_en;
    logic      ram_rd_en;

    // qualify the one-hot channel with its strobe
    assign push = vc_num_wr & {`FB_NUM_VC{wr_en}};
    assign pop  = vc_num_rd & {`FB_NUM_VC{rd_en}};

    // vc field dropped, only flags and payload stored
    assign ram_din.hdr_flag  = din.hdr_flag;
    assign ram_din.tail_flag = din.tail_flag;
    assign ram_din.payload   = din.payload;

    // ram only touched for accepted operations
    assign ram_wr_en = |push_ok;
    assign ram_rd_en = |pop_ok;

    generate
        for (genvar i = 0; i < `FB_NUM_VC; i++) begin : g_vc
            vc_depth_counter u_depth (
                .clk       (clk),
                .reset     (reset),
                .push      (push[i]),
                .pop       (pop[i]),
                .wr_ptr    (wr_ptrs[i]),
                .rd_ptr    (rd_ptrs[i]),
                .push_ok   (push_ok[i]),
                .pop_ok    (pop_ok[i]),
                .not_empty (vc_not_empty[i])
            );
        end
    endgenerate

    // write side address
    vc_addr_select u_wr_sel (
        .vc_sel (vc_num_wr),
        .ptrs   (wr_ptrs),
        .addr   (wr_addr)
    );

    // read side address
    vc_addr_select u_rd_sel (
        .vc_sel (vc_num_rd),
        .ptrs   (rd_ptrs),
        .addr   (rd_addr)
    );

    // dout comes straight off the ram read register
    flit_ram u_ram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .rd_en   (ram_rd_en),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (ram_din),
        .rd_data (dout)
    );

endmodule

`default_nettype wire

// ==== verif/flit_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_settings.svh"

module flit_buffer_tb
    import flit_buffer_pkg::*;
();

    localparam int NUM_VC      = `FB_NUM_VC;
    localparam int SLOTS       = `FB_SLOTS_PER_VC;
    localparam int WAIT_LIMIT  = 20;
    localparam int DRAIN_LIMIT = 64;

    typedef logic [`FB_PAYLOAD_W-1:0] payload_t;

    // one cycle's outcome from the queue model
    typedef struct packed {
        logic      pop_hit;
        ram_word_t flit;
        vc_mask_t  not_empty;
    } ref_result_t;

    logic      clk;
    logic      reset;
    flit_t     din;
    vc_mask_t  vc_num_wr;
    vc_mask_t  vc_num_rd;
    logic      wr_en;
    logic      rd_en;
    ram_word_t dout;
    vc_mask_t  vc_not_empty;

    // reference model with one queue per channel
    ram_word_t model_q [`FB_NUM_VC][$];
    vc_mask_t  exp_not_empty;
    ram_word_t exp_dout;
    logic      dout_valid;
    integer    seed;

    flit_buffer dut_i (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
            input logic [63:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while %s", what);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    // flags taken from the low payload bits so they vary
    function automatic flit_t make_flit(input vc_mask_t vc, input logic [31:0] p);
        flit_t f;
        f.hdr_flag  = p[0];
        f.tail_flag = p[1];
        f.vc        = vc;
        f.payload   = payload_t'(p);
        return f;
    endfunction

    // push and pop both judged on the occupancy before the edge
    function automatic ref_result_t apply_cycle(input flit_t f, input logic w,
            input vc_mask_t wvc, input logic r, input vc_mask_t rvc);
        ref_result_t res;
        ram_word_t   word;
        int          size_before [`FB_NUM_VC];
        res            = '0;
        word.hdr_flag  = f.hdr_flag;
        word.tail_flag = f.tail_flag;
        word.payload   = f.payload;
        for (int i = 0; i < NUM_VC; i++) begin
            size_before[i] = model_q[i].size();
        end
        for (int i = 0; i < NUM_VC; i++) begin
            if (r && rvc[i] && size_before[i] > 0) begin
                res.pop_hit = 1'b1;
                res.flit    = model_q[i].pop_front();
            end
            // full channel drops the write
            if (w && wvc[i] && size_before[i] < SLOTS) begin
                model_q[i].push_back(word);
            end
        end
        for (int i = 0; i < NUM_VC; i++) begin
            res.not_empty[i] = (model_q[i].size() != 0);
        end
        return res;
    endfunction

    // inputs change on the falling edge and expectations target the next rising edge
    task automatic drive_cycle(input logic w, input vc_mask_t wvc, input logic [31:0] p,
            input logic r, input vc_mask_t rvc);
        flit_t       f;
        ref_result_t res;
        f = make_flit(wvc, p);
        @(negedge clk);
        din       = f;
        wr_en     = w;
        vc_num_wr = wvc;
        rd_en     = r;
        vc_num_rd = rvc;
        res = apply_cycle(f, w, wvc, r, rvc);
        exp_not_empty = res.not_empty;
        if (res.pop_hit) begin
            exp_dout   = res.flit;
            dout_valid = 1'b1;
        end
    endtask

    task automatic write_flit(input vc_mask_t vc, input logic [31:0] p);
        drive_cycle(1'b1, vc, p, 1'b0, '0);
    endtask

    task automatic read_flit(input vc_mask_t vc);
        drive_cycle(1'b0, '0, 32'h0, 1'b1, vc);
    endtask

    task automatic idle();
        drive_cycle(1'b0, '0, 32'h0, 1'b0, '0);
    endtask

    // bounded wait for all channels to report empty
    task automatic wait_all_empty(input string what);
        int guard;
        guard = 0;
        while (vc_not_empty != '0) begin
            if (guard >= WAIT_LIMIT) begin
                report_timeout(what);
            end
            @(negedge clk);
            guard++;
        end
    endtask

    // pops the lowest non-empty channel until nothing is left
    task automatic drain_all();
        int       guard;
        vc_mask_t pick;
        guard = 0;
        // let the last driven strobes land before sampling the levels
        idle();
        while (vc_not_empty != '0) begin
            if (guard >= DRAIN_LIMIT) begin
                report_timeout("draining the channels");
            end
            pick = vc_not_empty & (~vc_not_empty + vc_mask_t'(1));
            read_flit(pick);
            guard++;
        end
        idle();
    endtask

    // compares a little after each rising edge once outputs have settled
    initial begin
        forever begin
            @(posedge clk);
            #2;
            check_value("vc_not_empty", 64'(vc_not_empty), 64'(exp_not_empty));
            if (dout_valid) begin
                check_value("dout", 64'(dout), 64'(exp_dout));
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic        heavy_wr;
        logic        w;
        logic        rd;
        vc_mask_t    vc0;
        vc_mask_t    vc1;
        seed          = 19;
        vc0           = vc_mask_t'(1);
        vc1           = vc_mask_t'(2);
        reset         = 1'b1;
        din           = '0;
        vc_num_wr     = '0;
        vc_num_rd     = '0;
        wr_en         = 1'b0;
        rd_en         = 1'b0;
        exp_not_empty = '0;
        exp_dout      = '0;
        dout_valid    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_all_empty("waiting for reset release");
        check_value("vc_not_empty", 64'(vc_not_empty), 64'h0);

        // write order kept on a single channel
        for (int i = 0; i < SLOTS; i++) write_flit(vc0, 32'h1000_0000 + i);
        for (int i = 0; i < SLOTS; i++) read_flit(vc0);

        // interleaved channels without crossing
        for (int i = 0; i < 3; i++) begin
            write_flit(vc0, 32'h2000_0000 + i);
            write_flit(vc1, 32'h3000_0000 + i);
        end
        for (int i = 0; i < 3; i++) begin
            read_flit(vc1);
            read_flit(vc0);
        end

        // overfill drops the extra two
        for (int i = 0; i < SLOTS + 2; i++) write_flit(vc1, 32'h4000_0000 + i);
        for (int i = 0; i < SLOTS; i++) read_flit(vc1);
        idle();
        check_value("vc_not_empty[1]", 64'(vc_not_empty[1]), 64'h0);

        // empty read ignored while a same-cycle write still lands
        drive_cycle(1'b1, vc1, 32'h5000_0001, 1'b1, vc0);
        read_flit(vc1);
        idle();

        // push+pop on a full channel and then on an empty one
        for (int i = 0; i < SLOTS; i++) write_flit(vc0, 32'h6000_0000 + i);
        drive_cycle(1'b1, vc0, 32'h6000_00ff, 1'b1, vc0);
        drain_all();
        drive_cycle(1'b1, vc0, 32'h7000_0001, 1'b1, vc0);
        drain_all();

        // random traffic in alternating write-heavy and read-heavy phases
        for (int cyc = 0; cyc < 400; cyc++) begin
            r        = $random(seed);
            heavy_wr = ((cyc / 100) % 2) == 0;
            w        = heavy_wr ? (r[1:0] != 2'b00) : (r[1:0] == 2'b00);
            rd       = heavy_wr ? (r[3:2] == 2'b00) : (r[3:2] != 2'b00);
            drive_cycle(w, vc_mask_t'(1 << (int'(r[8:4]) % NUM_VC)), $random(seed),
                        rd, vc_mask_t'(1 << (int'(r[13:9]) % NUM_VC)));
        end
        drain_all();
        idle();
        idle();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/flit_buffer_pkg.sv
src/vc_depth_counter.sv
src/vc_addr_select.sv
src/flit_ram.sv
src/flit_buffer.sv
verif/flit_buffer_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f all.f --top-module flit_buffer_tb -Mdir obj_dir
	out=$$(./obj_dir/Vflit_buffer_tb); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
